//--- all.f
common/lsu_pkg.sv
common/axi_pkg.sv
lsu/store_align.sv
lsu/load_extract.sv
lsu/lsu_ctrl.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
dv/clock_gen.sv
dv/tb_lsu.sv

//--- Makefile
# Verilator flow for the load/store unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  localparam int          PERIOD_NS    = 8;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'ha12c35e5;
  localparam int          USED_WORDS   = 32;
  localparam int          RANDOM_OPS   = 400;
  localparam int          NUM_OPS      = 2 * USED_WORDS + 9 + RANDOM_OPS;
  localparam int          WATCHDOG_NS  = (NUM_OPS * 20 + RESET_CYCLES) * PERIOD_NS;
  localparam int          BYTE_BITS    = DMEM_ADDR_BITS + 2;
  localparam logic [31:0] DMEM_END     = DMEM_BASE + 32'(4 * DMEM_WORDS);

  // RISC-V funct3 codes.
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;
  localparam logic [2:0] SB  = 3'b000;
  localparam logic [2:0] SH  = 3'b001;
  localparam logic [2:0] SW  = 3'b010;

  logic         clock;
  logic         reset;
  logic         ren;
  logic         wen;
  access_code_u op;
  logic [31:0]  addr;
  logic [31:0]  wsrc;
  logic [31:0]  rdata;
  logic         read_done;
  logic         write_done;
  logic         err;

  logic [7:0]   model_mem [4 * DMEM_WORDS]; // byte image of the data memory.
  logic         busy;
  logic         exp_write;
  logic         exp_err;
  logic [31:0]  exp_rdata;
  logic         reset_q;

  clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  lsu_top UUT (
    .clock      (clock),
    .reset      (reset),
    .ren        (ren),
    .wen        (wen),
    .op         (op),
    .addr       (addr),
    .wsrc       (wsrc),
    .rdata      (rdata),
    .read_done  (read_done),
    .write_done (write_done),
    .err        (err)
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic logic in_window(input logic [31:0] a);
    return (a >= DMEM_BASE) && (a < DMEM_END);
  endfunction

  function automatic logic [7:0] model_byte(input logic [31:0] a, input logic [1:0] k);
    return model_mem[{a[BYTE_BITS-1:2], a[1:0] + k}];
  endfunction

  // little-endian gather from the model, then sign or zero extension.
  function automatic logic [31:0] predict_load(input logic [2:0] code, input logic [31:0] a);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = model_byte(a, 2'd0);
    b1 = model_byte(a, 2'd1);
    case (code)
      LB:      return {{24{b0[7]}}, b0};
      LBU:     return {24'h0, b0};
      LH:      return {{16{b1[7]}}, b1, b0};
      LHU:     return {16'h0, b1, b0};
      default: return {model_byte(a, 2'd3), model_byte(a, 2'd2), b1, b0};
    endcase
  endfunction

  task automatic model_store(input logic [2:0] code, input logic [31:0] a,
                             input logic [31:0] data);
    int nbytes;
    case (code[1:0])
      2'd0:    nbytes = 1;
      2'd1:    nbytes = 2;
      default: nbytes = 4;
    endcase
    for (int k = 0; k < nbytes; k++) begin
      model_mem[{a[BYTE_BITS-1:2], a[1:0] + 2'(k)}] = data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] random_addr(input logic [2:0] code);
    logic [31:0] word_addr;
    logic [1:0]  offset;
    word_addr = DMEM_BASE + 32'(4 * ($urandom % USED_WORDS));
    offset    = 2'($urandom);
    if (code[1:0] == 2'd1) begin
      offset[0] = 1'b0; // halfwords sit on even bytes.
    end else if (code[1:0] == 2'd2) begin
      offset = 2'd0;
    end
    return word_addr + {30'd0, offset};
  endfunction

  // one request held until its done pulse, then dropped on that same edge.
  task automatic run_access(input logic rd, input logic wr, input logic [2:0] code,
                            input logic [31:0] a, input logic [31:0] data);
    logic [31:0] expected;
    expected = (!wr && in_window(a)) ? predict_load(code, a) : 32'h0;
    @(posedge clock);
    ren       <= rd;
    wen       <= wr;
    op.raw    <= code;
    addr      <= a;
    wsrc      <= data;
    exp_write <= wr;
    exp_err   <= !in_window(a);
    exp_rdata <= expected;
    busy      <= 1'b1;
    @(posedge clock);
    while (!(read_done || write_done)) begin
      @(posedge clock);
    end
    ren  <= 1'b0;
    wen  <= 1'b0;
    busy <= 1'b0;
    if (wr && in_window(a)) begin
      model_store(code, a, data);
    end
  endtask

  task automatic random_access();
    int unsigned pick;
    logic [2:0]  code;
    pick = $urandom % 8;
    case (pick)
      0:       code = SB;
      1:       code = SH;
      2:       code = SW;
      3:       code = LB;
      4:       code = LH;
      5:       code = LW;
      6:       code = LBU;
      default: code = LHU;
    endcase
    run_access(pick > 2, pick <= 2, code, random_addr(code), $urandom);
  endtask

  always @(posedge clock) begin
    reset_q <= reset;
  end

  assert property (@(posedge clock) reset_q |-> !read_done && !write_done && !err)
    else report_failure("a done pulse or err was high during or just after reset");
  assert property (@(posedge clock) disable iff (reset) read_done |-> !exp_write)
    else report_failure("read_done answered a store request");
  assert property (@(posedge clock) disable iff (reset) write_done |-> exp_write)
    else report_failure("write_done answered a load request");
  assert property (@(posedge clock) disable iff (reset) (read_done || write_done) |-> busy)
    else report_failure("a done pulse came with no request outstanding");
  assert property (@(posedge clock) disable iff (reset) read_done |=> !read_done)
    else report_failure("read_done was high for more than one cycle");
  assert property (@(posedge clock) disable iff (reset) write_done |=> !write_done)
    else report_failure("write_done was high for more than one cycle");
  assert property (@(posedge clock) disable iff (reset) read_done |-> rdata == exp_rdata)
    else report_failure($sformatf("Mismatch rdata at %08h: expected %08h, got %08h",
                                  $sampled(addr), $sampled(exp_rdata), $sampled(rdata)));
  assert property (@(posedge clock) disable iff (reset)
                   (read_done || write_done) |-> err == exp_err)
    else report_failure($sformatf("Mismatch err at %08h: expected %h, got %h",
                                  $sampled(addr), $sampled(exp_err), $sampled(err)));

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all accesses completed");
  end

  initial begin
    void'($urandom(SEED));
    ren       <= 1'b0;
    wen       <= 1'b0;
    op.raw    <= 3'b000;
    addr      <= 32'h0;
    wsrc      <= 32'h0;
    busy      <= 1'b0;
    exp_write <= 1'b0;
    exp_err   <= 1'b0;
    exp_rdata <= 32'h0;
    repeat (RESET_CYCLES) @(posedge clock);
    while (reset) begin
      @(posedge clock);
    end

    for (int w = 0; w < USED_WORDS; w++) begin
      run_access(1'b0, 1'b1, SW, DMEM_BASE + 32'(4 * w), $urandom);
    end
    for (int w = 0; w < USED_WORDS; w++) begin
      run_access(1'b1, 1'b0, LW, DMEM_BASE + 32'(4 * w), 32'h0);
    end

    // the first two would land on words 0 and 1 if the range check wrapped.
    run_access(1'b0, 1'b1, SW, DMEM_END, 32'hdead_beef);
    run_access(1'b0, 1'b1, SH, DMEM_END + 32'd6, 32'h0000_a5a5);
    run_access(1'b0, 1'b1, SB, DMEM_BASE - 32'd4, 32'h0000_0077);
    run_access(1'b1, 1'b0, LW, DMEM_END, 32'h0);
    run_access(1'b1, 1'b0, LB, DMEM_BASE - 32'd1, 32'h0);
    run_access(1'b1, 1'b0, LW, DMEM_BASE, 32'h0);
    run_access(1'b1, 1'b0, LW, DMEM_BASE + 32'd4, 32'h0);

    run_access(1'b1, 1'b1, SW, DMEM_BASE + 32'd8, $urandom);
    run_access(1'b1, 1'b0, LW, DMEM_BASE + 32'd8, 32'h0);

    repeat (RANDOM_OPS) begin
      random_access();
    end

    repeat (4) @(posedge clock); // a stray done pulse would still be caught here.
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  always begin
    clock = 1'b0;
    #(PERIOD_NS / 2);
    clock = 1'b1;
    #(PERIOD_NS / 2);
  end

  // reset is released on a rising edge, like every other testbench input.
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        ren,
  input  logic                        wen,
  input  lsu_pkg::access_code_u       op,
  input  logic [axi_pkg::ADDR_W-1:0]  addr,
  input  logic [axi_pkg::DATA_W-1:0]  wsrc,
  output logic [axi_pkg::DATA_W-1:0]  rdata,
  output logic                        read_done,
  output logic                        write_done,
  output logic                        err
);

  import axi_pkg::*;

  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] bus_rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic              rdata_load;

  lsu_ctrl u_ctrl (
    .clock      (clock),
    .reset      (reset),
    .ren        (ren),
    .wen        (wen),
    .read_done  (read_done),
    .write_done (write_done),
    .err        (err),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rresp      (rresp),
    .rready     (rready),
    .awvalid    (awvalid),
    .awready    (awready),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .bready     (bready),
    .rdata_load (rdata_load)
  );

  store_align u_store_align (
    .op       (op),
    .addr_low (addr[1:0]),
    .wsrc     (wsrc),
    .wdata    (wdata),
    .wstrb    (wstrb)
  );

  load_extract u_load_extract (
    .clock     (clock),
    .reset     (reset),
    .op        (op),
    .addr_low  (addr[1:0]),
    .bus_rdata (bus_rdata),
    .load      (rdata_load),
    .rdata     (rdata)
  );

  // both address channels carry the core address unchanged.
  axi_sram u_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (addr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (bus_rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (addr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

`default_nettype wire

//--- hdl/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
  input  logic                        clock,
  input  logic                        reset,

  input  logic [axi_pkg::ADDR_W-1:0]  araddr,
  input  logic                        arvalid,
  output logic                        arready,

  output logic [axi_pkg::DATA_W-1:0]  rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,

  input  logic [axi_pkg::ADDR_W-1:0]  awaddr,
  input  logic                        awvalid,
  output logic                        awready,

  input  logic [axi_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_pkg::STRB_W-1:0]  wstrb,
  input  logic                        wvalid,
  output logic                        wready,

  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready
);

  import axi_pkg::*;
  import lsu_pkg::*;

  logic [DATA_W-1:0]         mem [DMEM_WORDS];
  logic [ADDR_W-1:0]         rd_addr;
  logic [ADDR_W-1:0]         wr_addr;
  logic [ADDR_W-1:0]         rd_offset;
  logic [ADDR_W-1:0]         wr_offset;
  logic                      rd_hit;
  logic                      wr_hit;
  logic [DMEM_ADDR_BITS-1:0] rd_index;
  logic [DMEM_ADDR_BITS-1:0] wr_index;
  logic                      rd_pend;
  logic                      wr_pend;

  // addresses below the base wrap around and fail the compare as well.
  assign rd_offset = rd_addr - DMEM_BASE;
  assign wr_offset = wr_addr - DMEM_BASE;
  assign rd_hit    = rd_offset < ADDR_W'(4 * DMEM_WORDS);
  assign wr_hit    = wr_offset < ADDR_W'(4 * DMEM_WORDS);
  assign rd_index  = rd_offset[DMEM_ADDR_BITS+1:2];
  assign wr_index  = wr_offset[DMEM_ADDR_BITS+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      wr_pend <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // each ready is a one-cycle pulse following the valid.
      arready <= arvalid && !arready && !rd_pend && !rvalid;
      awready <= awvalid && !awready;
      wready  <= wvalid && !wready && !wr_pend && !bvalid;

      rd_pend <= arvalid && arready;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      wr_pend <= wvalid && wready;
      if (wr_pend) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
    if (rd_pend) begin
      rdata <= rd_hit ? mem[rd_index] : '0;
      rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end

    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
    if (wvalid && wready && wr_hit) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb[i]) begin
          mem[wr_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
    if (wr_pend) begin
      bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR; // the write was already dropped.
    end
  end

endmodule

`default_nettype wire

//--- lsu/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
  input  logic       clock,
  input  logic       reset,

  input  logic       ren,
  input  logic       wen,
  output logic       read_done,
  output logic       write_done,
  output logic       err,

  output logic       arvalid,
  input  logic       arready,

  input  logic       rvalid,
  input  logic [1:0] rresp,
  output logic       rready,

  output logic       awvalid,
  input  logic       awready,

  output logic       wvalid,
  input  logic       wready,

  input  logic       bvalid,
  input  logic [1:0] bresp,
  output logic       bready,

  output logic       rdata_load
);

  import axi_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RADDR,
    ST_RDATA,
    ST_WADDR,
    ST_WDATA,
    ST_BRESP,
    ST_DONE
  } state_e;

  state_e state;

  // the load result is captured on the same edge as the R transfer.
  assign rdata_load = (state == ST_RDATA) && rvalid && rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_IDLE;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      bready     <= 1'b0;
      read_done  <= 1'b0;
      write_done <= 1'b0;
      err        <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // a store takes priority when both requests are raised.
          if (wen) begin
            awvalid <= 1'b1;
            err     <= 1'b0;
            state   <= ST_WADDR;
          end else if (ren) begin
            arvalid <= 1'b1;
            err     <= 1'b0;
            state   <= ST_RADDR;
          end
        end

        ST_RADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= ST_RDATA;
          end
        end

        ST_RDATA: begin
          if (rvalid) begin
            rready    <= 1'b0;
            err       <= (rresp != RESP_OKAY);
            read_done <= 1'b1;
            state     <= ST_DONE;
          end
        end

        ST_WADDR: begin
          if (awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1; // data goes out only once the address is taken.
            state   <= ST_WDATA;
          end
        end

        ST_WDATA: begin
          if (wready) begin
            wvalid <= 1'b0;
            bready <= 1'b1;
            state  <= ST_BRESP;
          end
        end

        ST_BRESP: begin
          if (bvalid) begin
            bready     <= 1'b0;
            err        <= (bresp != RESP_OKAY);
            write_done <= 1'b1;
            state      <= ST_DONE;
          end
        end

        default: begin
          // done lasts one cycle; err stays until the next request.
          read_done  <= 1'b0;
          write_done <= 1'b0;
          state      <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- lsu/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
  input  logic                        clock,
  input  logic                        reset,
  input  lsu_pkg::access_code_u       op,
  input  logic [1:0]                  addr_low,
  input  logic [axi_pkg::DATA_W-1:0]  bus_rdata,
  input  logic                        load,
  output logic [axi_pkg::DATA_W-1:0]  rdata
);

  import lsu_pkg::*;

  logic [31:0] shifted;
  logic [31:0] extended;
  logic        fill;

  assign shifted = bus_rdata >> {addr_low, 3'b000};

  always_comb begin
    case (op.fields.size)
      SIZE_BYTE: begin
        fill     = ~op.fields.unsigned_load & shifted[7];
        extended = {{24{fill}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        fill     = ~op.fields.unsigned_load & shifted[15];
        extended = {{16{fill}}, shifted[15:0]};
      end
      default: begin
        fill     = 1'b0;
        extended = shifted;
      end
    endcase
  end

  // holds the last loaded value until the next load.
  always_ff @(posedge clock) begin
    if (reset) begin
      rdata <= '0;
    end else if (load) begin
      rdata <= extended;
    end
  end

endmodule

`default_nettype wire

//--- lsu/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  lsu_pkg::access_code_u       op,
  input  logic [1:0]                  addr_low,
  input  logic [axi_pkg::DATA_W-1:0]  wsrc,
  output logic [axi_pkg::DATA_W-1:0]  wdata,
  output logic [axi_pkg::STRB_W-1:0]  wstrb
);

  import lsu_pkg::*;

  // data moves up into the addressed lanes; aligned words shift by zero.
  assign wdata = wsrc << {addr_low, 3'b000};

  always_comb begin
    case (op.fields.size)
      SIZE_BYTE: wstrb = 4'b0001 << addr_low;
      SIZE_HALF: wstrb = 4'b0011 << addr_low; // addr_low is 0 or 2 here.
      default:   wstrb = 4'b1111;
    endcase
  end

endmodule

`default_nettype wire

//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // low two bits of a RISC-V load/store funct3 code.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  typedef struct packed {
    logic         unsigned_load; // funct3[2], set for lbu and lhu.
    access_size_e size;
  } access_fields_t;

  // the same funct3 bits, seen either as the raw code or split into fields.
  typedef union packed {
    logic [2:0]     raw;
    access_fields_t fields;
  } access_code_u;

  // data memory window.
  localparam logic [31:0] DMEM_BASE      = 32'h8000_0000;
  localparam int          DMEM_WORDS     = 1024;
  localparam int          DMEM_ADDR_BITS = 10;

endpackage

`default_nettype wire
